// File: files.f
+incdir+hw
hw/radio_ctrl_pkg.sv
hw/radio_sample_pkg.sv
hw/db_control.sv
hw/fe_control.sv
hw/radio_core.sv
sim/radio_core_props.sv
sim/radio_core_tb.sv

// File: Makefile
# Verilator build and run for the radio core testbench

VERILATOR ?= verilator
TOP       ?= radio_core_tb
FILELIST  ?= files.f
MDIR      ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=

SOURCES   := $(wildcard hw/*.sv hw/*.svh sim/*.sv)
COMMON    := --assert --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build: $(MDIR)/V$(TOP)

$(MDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(COMMON) --Mdir $(MDIR) $(VFLAGS)

# Exit status of the simulation is the test result
run: build
	./$(MDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

clean:
	rm -rf $(MDIR)

// File: sim/radio_core_tb.sv
// Radio core testbench: directed tests of controller registers, readback and IQ correction
`include "radio_defs.svh"

module radio_core_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import radio_ctrl_pkg::*;
   import radio_sample_pkg::*;

   localparam int NB          = `RADIO_NUM_DBOARDS;
   localparam int NCH         = `RADIO_NUM_CHANS;
   localparam int CPB         = `RADIO_CHANS_PER_DB;
   localparam int RB_TIMEOUT  = 20;
   localparam int STB_TIMEOUT = 10;
   localparam logic [7:0] RX0_ADDR = `RADIO_SR_RX_FE_BASE;
   localparam logic [7:0] RX1_ADDR = `RADIO_SR_RX_FE_BASE + `RADIO_SR_FE_CHAN_OFFSET;
   localparam logic [7:0] TX_ADDR  = `RADIO_SR_TX_FE_BASE;

   logic                                radio_clk;
   logic                                i_arst_n;
   settings_bus_t [NB-1:0]              set_bus;
   rb_req_t [NB-1:0]                    rb_req;
   rb_resp_t [NB-1:0]                   rb_resp;
   sample_t [NB-1:0]                    rx_adc;
   sample_t [NCH-1:0]                   rx_data;
   logic [NCH-1:0]                      rx_stb;
   sample_t [NB-1:0]                    tx_data;
   sample_t [NB-1:0]                    tx_dac;
   logic [NB-1:0][`RADIO_DB_IO_W-1:0]   gpio_in;
   logic [NB-1:0][`RADIO_DB_IO_W-1:0]   gpio_out;
   logic [NB-1:0][`RADIO_DB_IO_W-1:0]   gpio_ddr;
   logic [NB-1:0][`RADIO_LED_W-1:0]     leds;
   logic [NB-1:0][`RADIO_DB_IO_W-1:0]   misc_out;
   logic [NB-1:0][`RADIO_DB_IO_W-1:0]   misc_in;
   logic [31:0]                         lfsr_q;

   radio_core dut_i
   (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_set         (set_bus),
      .i_rb_req      (rb_req),
      .o_rb_resp     (rb_resp),
      .i_rx_adc      (rx_adc),
      .o_rx_data     (rx_data),
      .o_rx_stb      (rx_stb),
      .i_tx_data     (tx_data),
      .o_tx_dac      (tx_dac),
      .i_db_gpio_in  (gpio_in),
      .o_db_gpio_out (gpio_out),
      .o_db_gpio_ddr (gpio_ddr),
      .o_leds        (leds),
      .o_misc_out    (misc_out),
      .i_misc_in     (misc_in)
   );

   initial
   begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // Mode bit 2 swaps, bit 1 negates I, bit 0 negates Q
   function automatic logic [31:0] corrected_sample(input logic [31:0] s, input logic [2:0] m);
      logic [15:0] i_val;
      logic [15:0] q_val;
      i_val = m[2] ? s[15:0] : s[31:16];
      q_val = m[2] ? s[31:16] : s[15:0];
      if (m[1])
         i_val = ~i_val + 16'd1;
      if (m[0])
         q_val = ~q_val + 16'd1;
      return {i_val, q_val};
   endfunction

   function automatic string indexed_name(input string base, input int idx);
      return $sformatf("%s[%0d]", base, idx);
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
         fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic write_reg(input int b, input logic [7:0] addr, input logic [31:0] data);
      @(negedge radio_clk);
      set_bus[b].stb  = 1'b1;
      set_bus[b].addr = addr;
      set_bus[b].data = data;
      @(negedge radio_clk);
      set_bus[b] = '0;
   endtask

   task automatic read_back(input int b, input logic [7:0] addr, output logic [63:0] data);
      int cycles;
      @(negedge radio_clk);
      rb_req[b].stb  = 1'b1;
      rb_req[b].addr = addr;
      cycles = 0;
      do
      begin
         @(negedge radio_clk);
         rb_req[b] = '0;
         cycles++;
      end
      while (rb_resp[b].stb !== 1'b1 && cycles < RB_TIMEOUT);
      assert (rb_resp[b].stb === 1'b1)
      else
         fail_run($sformatf("No readback response from board %0d within %0d cycles",
                            b, RB_TIMEOUT));
      data = rb_resp[b].data;
   endtask

   // One of the seven observable outputs of a board
   function automatic logic [31:0] board_output(input int b, input int k);
      case (k)
         0:       return gpio_out[b];
         1:       return gpio_ddr[b];
         2:       return 32'(leds[b]);
         3:       return misc_out[b];
         4:       return rx_data[b*CPB];
         5:       return rx_data[b*CPB+1];
         default: return tx_dac[b];
      endcase
   endfunction

   task automatic check_all_zero(input string when);
      string names [7] = '{"o_db_gpio_out", "o_db_gpio_ddr", "o_leds", "o_misc_out",
                           "o_rx_data(2b)", "o_rx_data(2b+1)", "o_tx_dac"};
      for (int b = 0; b < NB; b++)
      begin
         for (int k = 0; k < 7; k++)
            check_value({indexed_name(names[k], b), " ", when}, 64'(board_output(b, k)), '0);
         check_value({indexed_name("o_rb_resp.stb", b), " ", when}, 64'(rb_resp[b].stb), '0);
         check_value({indexed_name("o_rb_resp.data", b), " ", when}, rb_resp[b].data, '0);
      end
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_reset_state();
      int cycles;
      for (int n = 0; n < 16; n++)
      begin
         @(negedge radio_clk);
         if (n == 8)
         begin
            check_all_zero("during reset");
            check_value("o_rx_stb during reset", 64'(rx_stb), '0);
         end
      end
      i_arst_n = 1'b1;
      cycles = 0;
      while (rx_stb !== '1 && cycles < STB_TIMEOUT)
      begin
         @(negedge radio_clk);
         cycles++;
      end
      assert (rx_stb === '1)
      else
         fail_run("o_rx_stb did not go high after reset release");
      // Zero inputs keep every register at zero past the first edges
      check_all_zero("after reset release");
   endtask

   task automatic test_db_writes();
      logic [31:0] g;
      logic [31:0] d;
      logic [31:0] l;
      logic [31:0] m;
      logic [63:0] rd;
      for (int b = 0; b < NB; b++)
      begin
         g = rand_bits(32);
         d = rand_bits(32);
         l = rand_bits(32);
         m = rand_bits(32);
         write_reg(b, SR_GPIO_OUT, g);
         check_value(indexed_name("o_db_gpio_out", b), 64'(gpio_out[b]), 64'(g));
         write_reg(b, SR_GPIO_DDR, d);
         check_value(indexed_name("o_db_gpio_ddr", b), 64'(gpio_ddr[b]), 64'(d));
         write_reg(b, SR_LEDS, l);
         check_value(indexed_name("o_leds", b), 64'(leds[b]), 64'(l[2:0]));
         write_reg(b, SR_MISC_OUT, m);
         check_value(indexed_name("o_misc_out", b), 64'(misc_out[b]), 64'(m));
         read_back(b, RB_GPIO_STATE, rd);
         check_value(indexed_name("o_rb_resp.data GPIO_STATE", b), rd, {d, g});
      end
   endtask

   task automatic test_readback_inputs();
      logic [63:0] rd;
      for (int b = 0; b < NB; b++)
      begin
         @(negedge radio_clk);
         gpio_in[b] = rand_bits(32);
         misc_in[b] = rand_bits(32);
         repeat (3) @(negedge radio_clk);
         read_back(b, RB_GPIO_IN, rd);
         check_value(indexed_name("o_rb_resp.data GPIO_IN", b), rd, {32'd0, gpio_in[b]});
         read_back(b, RB_MISC_IN, rd);
         check_value(indexed_name("o_rb_resp.data MISC_IN", b), rd, {32'd0, misc_in[b]});
         read_back(b, 8'h5a, rd);
         check_value(indexed_name("o_rb_resp.data unknown address", b), rd, '0);
      end
   endtask

   // Channel 1 gets the complement mode, so the two channels always differ
   task automatic test_rx_correction();
      logic [31:0] s;
      logic [2:0]  m;
      for (int b = 0; b < NB; b++)
      begin
         for (int mode = 0; mode < 8; mode++)
         begin
            m = 3'(mode);
            write_reg(b, RX0_ADDR, {29'(rand_bits(29)), m});
            write_reg(b, RX1_ADDR, {29'(rand_bits(29)), ~m});
            for (int n = 0; n < 2; n++)
            begin
               s = rand_bits(32);
               rx_adc[b] = s;
               @(negedge radio_clk);
               check_value(indexed_name("o_rx_data", b*CPB), 64'(rx_data[b*CPB]),
                           64'(corrected_sample(s, m)));
               check_value(indexed_name("o_rx_data", b*CPB+1), 64'(rx_data[b*CPB+1]),
                           64'(corrected_sample(s, ~m)));
            end
         end
      end
   endtask

   task automatic test_tx_correction();
      logic [31:0] s;
      logic [2:0]  m;
      for (int b = 0; b < NB; b++)
      begin
         for (int mode = 0; mode < 8; mode++)
         begin
            m = 3'(mode);
            write_reg(b, TX_ADDR, {29'(rand_bits(29)), m});
            for (int n = 0; n < 2; n++)
            begin
               s = rand_bits(32);
               tx_data[b] = s;
               @(negedge radio_clk);
               check_value(indexed_name("o_tx_dac", b), 64'(tx_dac[b]),
                           64'(corrected_sample(s, m)));
            end
         end
      end
   endtask

   // Inputs of the other board stay constant, so its outputs must not move
   task automatic test_board_independence();
      logic [7:0]  addrs [7] = '{SR_GPIO_OUT, SR_GPIO_DDR, SR_LEDS, SR_MISC_OUT,
                                 RX0_ADDR, RX1_ADDR, TX_ADDR};
      logic [31:0] snap [7];
      int          o;
      for (int b = 0; b < NB; b++)
      begin
         o = NB - 1 - b;
         for (int k = 0; k < 7; k++)
            snap[k] = board_output(o, k);
         for (int k = 0; k < 7; k++)
            write_reg(b, addrs[k], rand_bits(32));
         @(negedge radio_clk);
         for (int k = 0; k < 7; k++)
            check_value($sformatf("board %0d output %0d after writes to board %0d", o, k, b),
                        64'(board_output(o, k)), 64'(snap[k]));
      end
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      lfsr_q   = 32'h7a69_b7e5;
      i_arst_n = 1'b1;
      set_bus  = '0;
      rb_req   = '0;
      rx_adc   = '0;
      tx_data  = '0;
      gpio_in  = '0;
      misc_in  = '0;
      #1 i_arst_n = 1'b0;
      test_reset_state();
      test_db_writes();
      test_readback_inputs();
      test_rx_correction();
      test_tx_correction();
      test_board_independence();
      $display("Everything OK");
      $finish;
   end

endmodule

// File: sim/radio_core_props.sv
// Radio core assertions: readback latency, reset values and receive strobe
`include "radio_defs.svh"

module radio_core_props
(
   input logic                                                radio_clk,
   input logic                                                i_arst_n,
   input radio_ctrl_pkg::rb_req_t [`RADIO_NUM_DBOARDS-1:0]    i_rb_req,
   input radio_ctrl_pkg::rb_resp_t [`RADIO_NUM_DBOARDS-1:0]   i_rb_resp,
   input radio_sample_pkg::sample_t [`RADIO_NUM_CHANS-1:0]    i_rx_data,
   input logic [`RADIO_NUM_CHANS-1:0]                         i_rx_stb,
   input radio_sample_pkg::sample_t [`RADIO_NUM_DBOARDS-1:0]  i_tx_dac,
   input logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]   i_gpio_out,
   input logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]   i_gpio_ddr,
   input logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_LED_W-1:0]     i_leds,
   input logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]   i_misc_out
);
   timeunit 1ns;
   timeprecision 1ps;

   // --------------------------------------------------
   // Readback response exactly one cycle after a request
   // --------------------------------------------------
   for (genvar b = 0; b < `RADIO_NUM_DBOARDS; b++)
   begin : g_rb
      a_resp_follows_req: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
         i_rb_req[b].stb |=> i_rb_resp[b].stb)
      else $error("Readback request on board %0d got no response", b);

      a_resp_was_requested: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
         i_rb_resp[b].stb |-> $past(i_rb_req[b].stb))
      else $error("Unrequested readback response on board %0d", b);
   end

   // All outputs held at zero in reset
   a_zero_in_reset: assert property (@(posedge radio_clk)
      !i_arst_n |-> (i_rb_resp == '0 && i_rx_data == '0 && i_rx_stb == '0 &&
                     i_tx_dac == '0 && i_gpio_out == '0 && i_gpio_ddr == '0 &&
                     i_leds == '0 && i_misc_out == '0))
   else $error("Outputs not zero during reset");

   // Sample strobe runs from the first edge after release
   a_rx_stb_high: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      $past(i_arst_n) |-> &i_rx_stb)
   else $error("o_rx_stb low after reset");

endmodule

bind radio_core radio_core_props props_i
(
   .radio_clk  (radio_clk),
   .i_arst_n   (i_arst_n),
   .i_rb_req   (i_rb_req),
   .i_rb_resp  (o_rb_resp),
   .i_rx_data  (o_rx_data),
   .i_rx_stb   (o_rx_stb),
   .i_tx_dac   (o_tx_dac),
   .i_gpio_out (o_db_gpio_out),
   .i_gpio_ddr (o_db_gpio_ddr),
   .i_leds     (o_leds),
   .i_misc_out (o_misc_out)
);

// File: hw/radio_core.sv
// Radio core top: daughterboard controllers and front ends for every board slot
`include "radio_defs.svh"

module radio_core
(
   input  logic                                                radio_clk,
   input  logic                                                i_arst_n,
   // Control buses, one per board
   input  radio_ctrl_pkg::settings_bus_t [`RADIO_NUM_DBOARDS-1:0] i_set,
   input  radio_ctrl_pkg::rb_req_t [`RADIO_NUM_DBOARDS-1:0]       i_rb_req,
   output radio_ctrl_pkg::rb_resp_t [`RADIO_NUM_DBOARDS-1:0]      o_rb_resp,
   // Sample streams
   input  radio_sample_pkg::sample_t [`RADIO_NUM_DBOARDS-1:0]     i_rx_adc,
   output radio_sample_pkg::sample_t [`RADIO_NUM_CHANS-1:0]       o_rx_data,
   output logic [`RADIO_NUM_CHANS-1:0]                            o_rx_stb,
   input  radio_sample_pkg::sample_t [`RADIO_NUM_DBOARDS-1:0]     i_tx_data,
   output radio_sample_pkg::sample_t [`RADIO_NUM_DBOARDS-1:0]     o_tx_dac,
   // Daughterboard pins
   input  logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]      i_db_gpio_in,
   output logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]      o_db_gpio_out,
   output logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]      o_db_gpio_ddr,
   output logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_LED_W-1:0]        o_leds,
   output logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]      o_misc_out,
   input  logic [`RADIO_NUM_DBOARDS-1:0][`RADIO_DB_IO_W-1:0]      i_misc_in
);

   for (genvar b = 0; b < `RADIO_NUM_DBOARDS; b++)
   begin : g_board
      logic rx_stb;

      // --------------------------------------------------
      // Daughterboard control
      // --------------------------------------------------
      db_control db_control_i
      (
         .radio_clk  (radio_clk),
         .i_arst_n   (i_arst_n),
         .i_set      (i_set[b]),
         .i_rb_req   (i_rb_req[b]),
         .o_rb_resp  (o_rb_resp[b]),
         .i_gpio_in  (i_db_gpio_in[b]),
         .o_gpio_out (o_db_gpio_out[b]),
         .o_gpio_ddr (o_db_gpio_ddr[b]),
         .o_leds     (o_leds[b]),
         .o_misc_out (o_misc_out[b]),
         .i_misc_in  (i_misc_in[b])
      );

      // --------------------------------------------------
      // Front end, channels 2b and 2b+1
      // --------------------------------------------------
      fe_control fe_control_i
      (
         .radio_clk (radio_clk),
         .i_arst_n  (i_arst_n),
         .i_set     (i_set[b]),
         .i_rx_adc  (i_rx_adc[b]),
         .o_rx_data (o_rx_data[b*`RADIO_CHANS_PER_DB +: `RADIO_CHANS_PER_DB]),
         .o_rx_stb  (rx_stb),
         .i_tx_data (i_tx_data[b]),
         .o_tx_dac  (o_tx_dac[b])
      );

      // Both channels of a board share the sample strobe
      assign o_rx_stb[b*`RADIO_CHANS_PER_DB +: `RADIO_CHANS_PER_DB] =
         {`RADIO_CHANS_PER_DB{rx_stb}};
   end

endmodule

// File: hw/fe_control.sv
// Front-end control: per-channel receive and transmit IQ swap and invert correction
`include "radio_defs.svh"

module fe_control
(
   input  logic                                                 radio_clk,
   input  logic                                                 i_arst_n,
   input  radio_ctrl_pkg::settings_bus_t                        i_set,
   input  radio_sample_pkg::sample_t                            i_rx_adc,
   output radio_sample_pkg::sample_t [`RADIO_CHANS_PER_DB-1:0]  o_rx_data,
   output logic                                                 o_rx_stb,
   input  radio_sample_pkg::sample_t                            i_tx_data,
   output radio_sample_pkg::sample_t                            o_tx_dac
);
   import radio_sample_pkg::*;

   sample_t  tx_r;
   fe_mode_t tx_mode_r;
   logic     rx_stb_r;

   // Swap first, then the two negations
   function automatic sample_t iq_correct(input sample_t s, input fe_mode_t m);
      sample_t r;
      r = s;
      if (m.swap_iq)
      begin
         r.i = s.q;
         r.q = s.i;
      end
      if (m.invert_i)
         r.i = -r.i;
      if (m.invert_q)
         r.q = -r.q;
      return r;
   endfunction

   // --------------------------------------------------
   // Receive path
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         rx_stb_r <= 1'b0;
      else
         rx_stb_r <= 1'b1;
   end

   // The board ADC feeds every receive channel
   for (genvar ch = 0; ch < `RADIO_CHANS_PER_DB; ch++)
   begin : g_rx
      localparam logic [`RADIO_SET_AW-1:0] MODE_ADDR =
         `RADIO_SR_RX_FE_BASE + 8'(ch) * `RADIO_SR_FE_CHAN_OFFSET;

      fe_mode_t mode_r;
      sample_t  rx_r;

      // Corrected sample registered once per channel
      always_ff @(posedge radio_clk or negedge i_arst_n)
      begin
         if (!i_arst_n)
         begin
            mode_r <= '0;
            rx_r   <= '0;
         end
         else
         begin
            if (i_set.stb && i_set.addr == MODE_ADDR)
               mode_r <= fe_mode_t'(i_set.data[FE_MODE_W-1:0]);
            rx_r <= iq_correct(i_rx_adc, mode_r);
         end
      end

      assign o_rx_data[ch] = rx_r;
   end

   assign o_rx_stb = rx_stb_r;

   // --------------------------------------------------
   // Transmit path
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         tx_mode_r <= '0;
         tx_r      <= '0;
      end
      else
      begin
         if (i_set.stb && i_set.addr == `RADIO_SR_TX_FE_BASE)
            tx_mode_r <= fe_mode_t'(i_set.data[FE_MODE_W-1:0]);
         tx_r <= iq_correct(i_tx_data, tx_mode_r);
      end
   end

   assign o_tx_dac = tx_r;

endmodule

// File: hw/db_control.sv
// Daughterboard controller: GPIO, LED and misc-output registers with readback
`include "radio_defs.svh"

module db_control
(
   input  logic                            radio_clk,
   input  logic                            i_arst_n,
   input  radio_ctrl_pkg::settings_bus_t   i_set,
   input  radio_ctrl_pkg::rb_req_t         i_rb_req,
   output radio_ctrl_pkg::rb_resp_t        o_rb_resp,
   input  logic [`RADIO_DB_IO_W-1:0]       i_gpio_in,
   output logic [`RADIO_DB_IO_W-1:0]       o_gpio_out,
   output logic [`RADIO_DB_IO_W-1:0]       o_gpio_ddr,
   output logic [`RADIO_LED_W-1:0]         o_leds,
   output logic [`RADIO_DB_IO_W-1:0]       o_misc_out,
   input  logic [`RADIO_DB_IO_W-1:0]       i_misc_in
);
   import radio_ctrl_pkg::*;

   localparam int PAD_W = `RADIO_RB_DW - `RADIO_DB_IO_W;

   logic [`RADIO_DB_IO_W-1:0] gpio_out_r;
   logic [`RADIO_DB_IO_W-1:0] gpio_ddr_r;
   logic [`RADIO_LED_W-1:0]   leds_r;
   logic [`RADIO_DB_IO_W-1:0] misc_out_r;
   logic [`RADIO_DB_IO_W-1:0] misc_in_r;
   logic [`RADIO_RB_DW-1:0]   rb_data_next;
   rb_resp_t                  rb_resp_r;

   // --------------------------------------------------
   // Settings registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         gpio_out_r <= '0;
         gpio_ddr_r <= '0;
         leds_r     <= '0;
         misc_out_r <= '0;
      end
      else if (i_set.stb)
      begin
         case (db_reg_e'(i_set.addr))
            SR_GPIO_OUT: gpio_out_r <= i_set.data;
            SR_GPIO_DDR: gpio_ddr_r <= i_set.data;
            SR_LEDS:     leds_r     <= i_set.data[`RADIO_LED_W-1:0];
            SR_MISC_OUT: misc_out_r <= i_set.data;
            default:     ;
         endcase
      end
   end

   // Misc input sampled every cycle
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         misc_in_r <= '0;
      else
         misc_in_r <= i_misc_in;
   end

   // --------------------------------------------------
   // Readback
   // --------------------------------------------------
   always_comb
   begin
      case (db_rb_e'(i_rb_req.addr))
         RB_GPIO_IN:    rb_data_next = {{PAD_W{1'b0}}, i_gpio_in};
         RB_MISC_IN:    rb_data_next = {{PAD_W{1'b0}}, misc_in_r};
         RB_GPIO_STATE: rb_data_next = {gpio_ddr_r, gpio_out_r};
         default:       rb_data_next = '0;
      endcase
   end

   // Response one cycle after the request, data bus idles at zero
   always_ff @(posedge radio_clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         rb_resp_r <= '0;
      else
      begin
         rb_resp_r.stb  <= i_rb_req.stb;
         rb_resp_r.data <= i_rb_req.stb ? rb_data_next : '0;
      end
   end

   assign o_rb_resp  = rb_resp_r;
   assign o_gpio_out = gpio_out_r;
   assign o_gpio_ddr = gpio_ddr_r;
   assign o_leds     = leds_r;
   assign o_misc_out = misc_out_r;

endmodule

// File: hw/radio_sample_pkg.sv
// Radio sample package: IQ sample layout and front-end correction mode
`include "radio_defs.svh"

package radio_sample_pkg;

   // --------------------------------------------------
   // IQ sample, I in the upper half
   // --------------------------------------------------
   typedef struct packed {
      logic signed [`RADIO_SAMPLE_W-1:0] i;
      logic signed [`RADIO_SAMPLE_W-1:0] q;
   } sample_t;

   // --------------------------------------------------
   // Correction mode, taken from bits 2..0 of a mode write
   // --------------------------------------------------
   typedef struct packed {
      logic swap_iq;
      logic invert_i;
      logic invert_q;
   } fe_mode_t;

   // Number of bits of a mode write that are kept
   localparam int FE_MODE_W = $bits(fe_mode_t);

endpackage

// File: hw/radio_ctrl_pkg.sv
// Radio control package: settings and readback bus types and register address maps
`include "radio_defs.svh"

package radio_ctrl_pkg;

   // One settings write, valid while stb is high
   typedef struct packed {
      logic                      stb;
      logic [`RADIO_SET_AW-1:0]  addr;
      logic [`RADIO_SET_DW-1:0]  data;
   } settings_bus_t;

   // Readback request, single cycle strobe
   typedef struct packed {
      logic                      stb;
      logic [`RADIO_SET_AW-1:0]  addr;
   } rb_req_t;

   // Readback response, one cycle after the request
   typedef struct packed {
      logic                      stb;
      logic [`RADIO_RB_DW-1:0]   data;
   } rb_resp_t;

   // Daughterboard controller settings addresses
   typedef enum logic [`RADIO_SET_AW-1:0] {
      SR_GPIO_OUT = `RADIO_SR_DB_BASE,
      SR_GPIO_DDR = `RADIO_SR_DB_BASE + 8'd1,
      SR_LEDS     = `RADIO_SR_DB_BASE + 8'd2,
      SR_MISC_OUT = `RADIO_SR_DB_BASE + 8'd3
   } db_reg_e;

   // Readback addresses
   typedef enum logic [`RADIO_SET_AW-1:0] {
      RB_GPIO_IN    = `RADIO_RB_DB_BASE,
      RB_MISC_IN    = `RADIO_RB_DB_BASE + 8'd1,
      RB_GPIO_STATE = `RADIO_RB_DB_BASE + 8'd2
   } db_rb_e;

endpackage

// File: hw/radio_defs.svh
// Radio core defines: board and channel counts, bus widths and register address bases
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// --------------------------------------------------
// Board and channel counts
// --------------------------------------------------
`define RADIO_NUM_DBOARDS        2
`define RADIO_CHANS_PER_DB       2
`define RADIO_NUM_CHANS          4

// --------------------------------------------------
// Bus and pin widths
// --------------------------------------------------
`define RADIO_SET_AW             8
`define RADIO_SET_DW             32
`define RADIO_RB_DW              64
`define RADIO_SAMPLE_W           16
`define RADIO_DB_IO_W            32
`define RADIO_LED_W              3

// --------------------------------------------------
// Register address bases
// --------------------------------------------------
`define RADIO_SR_DB_BASE         8'd160
`define RADIO_SR_TX_FE_BASE      8'd208
`define RADIO_SR_RX_FE_BASE      8'd224
`define RADIO_SR_FE_CHAN_OFFSET  8'd16
`define RADIO_RB_DB_BASE         8'd16

`endif
